//--- cache_pkg.sv
// Shared widths and vector types for the cache.
// APB register byte offsets and the version word.

package cache_pkg;

   // ========================================
   // Widths and types
   // ========================================

   // Word address and data widths.
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [DATA_W-1:0] cnt_t;

   // APB byte address width.
   localparam int APB_AW = 8;

   typedef logic [APB_AW-1:0] apb_addr_t;

   // ========================================
   // Register map
   // ========================================

   localparam apb_addr_t REG_HIT        = 8'h00;
   localparam apb_addr_t REG_MISS       = 8'h04;
   localparam apb_addr_t REG_READ_HIT   = 8'h08;
   localparam apb_addr_t REG_READ_MISS  = 8'h0C;
   localparam apb_addr_t REG_WRITE_HIT  = 8'h10;
   localparam apb_addr_t REG_WRITE_MISS = 8'h14;
   // Write-only commands.
   localparam apb_addr_t REG_RST_CNTRS  = 8'h18;
   localparam apb_addr_t REG_INVALIDATE = 8'h1C;
   // Write buffer status flags.
   localparam apb_addr_t REG_WTB_EMPTY  = 8'h20;
   localparam apb_addr_t REG_WTB_FULL   = 8'h24;
   localparam apb_addr_t REG_VERSION    = 8'h28;

   // Major 1, minor 2, patch 0.
   localparam data_t CACHE_VERSION = 32'h0001_0200;

endpackage

//--- cache_front.sv
// CPU request register and CPU valid/ready handshake.

`timescale 1ns/1ps

module cache_front (
   input  logic             clk_i,
   input  logic             arst_i,
   // CPU side.
   input  logic             cpu_valid_i,
   input  logic             cpu_we_i,
   input  cache_pkg::addr_t cpu_addr_i,
   input  cache_pkg::data_t cpu_wdata_i,
   output logic             cpu_ready_o,
   output cache_pkg::data_t cpu_rdata_o,
   // Core side.
   input  logic             req_done_i,
   input  cache_pkg::data_t rsp_data_i,
   output logic             req_valid_o,
   output logic             req_we_o,
   output cache_pkg::addr_t req_addr_o,
   output cache_pkg::data_t req_wdata_o
);

   logic             busy_q;
   logic             we_q;
   cache_pkg::addr_t addr_q;
   cache_pkg::data_t wdata_q;
   logic             capture;

   // A new request is taken only while no request is held.
   assign capture = cpu_valid_i && !busy_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_q <= 1'b0;
         we_q   <= 1'b0;
      end else begin
         if (req_done_i) begin
            busy_q <= 1'b0;
         end else if (capture) begin
            busy_q <= 1'b1;
            we_q   <= cpu_we_i;
         end
      end
   end

   // Address and write data of the held request.
   always_ff @(posedge clk_i) begin
      if (capture) begin
         addr_q  <= cpu_addr_i;
         wdata_q <= cpu_wdata_i;
      end
   end

   // ========================================
   // Outputs
   // ========================================

   assign req_valid_o = busy_q;
   assign req_we_o    = we_q;
   assign req_addr_o  = addr_q;
   assign req_wdata_o = wdata_q;

   // One-cycle ready, in the cycle the core finishes.
   assign cpu_ready_o = busy_q && req_done_i;
   assign cpu_rdata_o = rsp_data_i;

endmodule

//--- cache_core.sv
// Direct-mapped cache core with valid, tag and data arrays.
// Hit/miss lookup, read refill FSM and access event pulses.

`timescale 1ns/1ps

module cache_core #(
   parameter int IDX_W = 4
) (
   input  logic             clk_i,
   input  logic             arst_i,
   // Request from the front.
   input  logic             req_valid_i,
   input  logic             req_we_i,
   input  cache_pkg::addr_t req_addr_i,
   input  cache_pkg::data_t req_wdata_i,
   output logic             req_done_o,
   output cache_pkg::data_t rsp_data_o,
   // Control.
   input  logic             invalidate_i,
   // Write buffer push.
   input  logic             wtb_full_i,
   input  logic             wtb_empty_i,
   output logic             wtb_push_o,
   output cache_pkg::addr_t wtb_addr_o,
   output cache_pkg::data_t wtb_data_o,
   // Refill read.
   input  logic             rd_done_i,
   input  cache_pkg::data_t rd_data_i,
   output logic             rd_req_o,
   output cache_pkg::addr_t rd_addr_o,
   // Access events.
   output logic             read_hit_o,
   output logic             read_miss_o,
   output logic             write_hit_o,
   output logic             write_miss_o
);

   localparam int LINES = 1 << IDX_W;
   localparam int TAG_W = cache_pkg::ADDR_W - IDX_W;

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      WAIT_EMPTY,
      REFILL
   } core_state_t;

   core_state_t      state_q;
   core_state_t      state_d;

   logic [LINES-1:0] valid_q;
   logic [TAG_W-1:0] tag_q  [LINES];
   cache_pkg::data_t data_q [LINES];

   logic [IDX_W-1:0] idx;
   logic [TAG_W-1:0] tag;
   logic             hit;
   logic             in_lookup;
   logic             write_go;
   logic             read_hit_go;
   logic             fill;

   // ========================================
   // Lookup
   // ========================================

   assign idx = req_addr_i[IDX_W-1:0];
   assign tag = req_addr_i[cache_pkg::ADDR_W-1:IDX_W];
   assign hit = valid_q[idx] && (tag_q[idx] == tag);

   assign in_lookup   = (state_q == LOOKUP);
   // Writes wait in LOOKUP while the buffer is full.
   assign write_go    = in_lookup && req_we_i && !wtb_full_i;
   assign read_hit_go = in_lookup && !req_we_i && hit;
   assign fill        = (state_q == REFILL) && rd_done_i;

   // ========================================
   // State machine
   // ========================================

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (req_valid_i) state_d = LOOKUP;
         end
         LOOKUP: begin
            if (req_we_i) begin
               if (!wtb_full_i) state_d = IDLE;
            end else if (hit) begin
               state_d = IDLE;
            end else begin
               state_d = WAIT_EMPTY;
            end
         end
         // Buffered writes reach memory before the refill read.
         WAIT_EMPTY: begin
            if (wtb_empty_i) state_d = REFILL;
         end
         REFILL: begin
            if (rd_done_i) state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= IDLE;
         valid_q <= '0;
      end else begin
         state_q <= state_d;
         if (invalidate_i) begin
            valid_q <= '0;
         end else if (fill) begin
            valid_q[idx] <= 1'b1;
         end
      end
   end

   // Tag and data arrays.
   always_ff @(posedge clk_i) begin
      if (fill) begin
         tag_q[idx]  <= tag;
         data_q[idx] <= rd_data_i;
      end else if (write_go && hit) begin
         data_q[idx] <= req_wdata_i;
      end
   end

   // ========================================
   // Outputs
   // ========================================

   assign req_done_o = write_go || read_hit_go || fill;
   // Refill data bypasses the array on a miss.
   assign rsp_data_o = fill ? rd_data_i : data_q[idx];

   // Every write goes through, hit or miss.
   assign wtb_push_o = write_go;
   assign wtb_addr_o = req_addr_i;
   assign wtb_data_o = req_wdata_i;

   assign rd_req_o  = (state_q == REFILL);
   assign rd_addr_o = req_addr_i;

   assign read_hit_o   = read_hit_go;
   assign read_miss_o  = fill;
   assign write_hit_o  = write_go && hit;
   assign write_miss_o = write_go && !hit;

endmodule

//--- cache_back_end.sv
// Write-through FIFO and memory port arbiter.
// Draining the FIFO goes first, refill reads pass only when it is empty.

`timescale 1ns/1ps

module cache_back_end #(
   parameter int WTB_DEPTH_LOG2 = 2
) (
   input  logic             clk_i,
   input  logic             arst_i,
   // Write push from the core.
   input  logic             wtb_push_i,
   input  cache_pkg::addr_t wtb_addr_i,
   input  cache_pkg::data_t wtb_data_i,
   output logic             wtb_full_o,
   output logic             wtb_empty_o,
   // Refill read from the core.
   input  logic             rd_req_i,
   input  cache_pkg::addr_t rd_addr_i,
   output logic             rd_done_o,
   output cache_pkg::data_t rd_data_o,
   // Memory port.
   input  logic             mem_ready_i,
   input  cache_pkg::data_t mem_rdata_i,
   output logic             mem_valid_o,
   output logic             mem_we_o,
   output cache_pkg::addr_t mem_addr_o,
   output cache_pkg::data_t mem_wdata_o
);

   localparam int DEPTH = 1 << WTB_DEPTH_LOG2;

   cache_pkg::addr_t          fifo_addr_q [DEPTH];
   cache_pkg::data_t          fifo_data_q [DEPTH];
   logic [WTB_DEPTH_LOG2-1:0] wr_ptr_q;
   logic [WTB_DEPTH_LOG2-1:0] rd_ptr_q;
   logic [WTB_DEPTH_LOG2:0]   count_q;
   logic                      fifo_empty;
   logic                      fifo_full;
   logic                      push;
   logic                      pop;

   assign fifo_empty = (count_q == '0);
   assign fifo_full  = (count_q == (WTB_DEPTH_LOG2 + 1)'(DEPTH));

   assign push = wtb_push_i && !fifo_full;
   // Head entry leaves on an accepted memory write.
   assign pop  = !fifo_empty && mem_ready_i;

   // ========================================
   // FIFO
   // ========================================

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         fifo_addr_q[wr_ptr_q] <= wtb_addr_i;
         fifo_data_q[wr_ptr_q] <= wtb_data_i;
      end
   end

   assign wtb_full_o  = fifo_full;
   assign wtb_empty_o = fifo_empty;

   // ========================================
   // Memory port
   // ========================================

   assign mem_valid_o = !fifo_empty || rd_req_i;
   assign mem_we_o    = !fifo_empty;
   assign mem_addr_o  = fifo_empty ? rd_addr_i : fifo_addr_q[rd_ptr_q];
   assign mem_wdata_o = fifo_data_q[rd_ptr_q];

   assign rd_done_o = fifo_empty && rd_req_i && mem_ready_i;
   assign rd_data_o = mem_rdata_i;

endmodule

//--- cache_ctrl.sv
// APB register block for the cache.
// Performance counters, counter clear, invalidate and buffer status.

`timescale 1ns/1ps

module cache_ctrl (
   input  logic                 clk_i,
   input  logic                 arst_i,
   // APB slave.
   input  logic                 apb_psel_i,
   input  logic                 apb_penable_i,
   input  logic                 apb_pwrite_i,
   input  cache_pkg::apb_addr_t apb_paddr_i,
   input  cache_pkg::data_t     apb_pwdata_i,
   output cache_pkg::data_t     apb_prdata_o,
   output logic                 apb_pready_o,
   // Access events from the core.
   input  logic                 read_hit_i,
   input  logic                 read_miss_i,
   input  logic                 write_hit_i,
   input  logic                 write_miss_i,
   // Write buffer status.
   input  logic                 wtb_empty_i,
   input  logic                 wtb_full_i,
   output logic                 invalidate_o
);

   cache_pkg::cnt_t  read_hit_q;
   cache_pkg::cnt_t  read_miss_q;
   cache_pkg::cnt_t  write_hit_q;
   cache_pkg::cnt_t  write_miss_q;
   cache_pkg::data_t rdata;
   logic             wr_access;
   logic             rst_cntrs;

   // No wait states.
   assign apb_pready_o = 1'b1;

   // Commands act at the end of the access cycle, data ignored.
   assign wr_access    = apb_psel_i && apb_penable_i && apb_pwrite_i;
   assign rst_cntrs    = wr_access && (apb_paddr_i == cache_pkg::REG_RST_CNTRS);
   assign invalidate_o = wr_access && (apb_paddr_i == cache_pkg::REG_INVALIDATE);

   // ========================================
   // Performance counters
   // ========================================

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         read_hit_q   <= '0;
         read_miss_q  <= '0;
         write_hit_q  <= '0;
         write_miss_q <= '0;
      end else if (rst_cntrs) begin
         read_hit_q   <= '0;
         read_miss_q  <= '0;
         write_hit_q  <= '0;
         write_miss_q <= '0;
      end else begin
         if (read_hit_i) read_hit_q <= read_hit_q + 1'b1;
         if (read_miss_i) read_miss_q <= read_miss_q + 1'b1;
         if (write_hit_i) write_hit_q <= write_hit_q + 1'b1;
         if (write_miss_i) write_miss_q <= write_miss_q + 1'b1;
      end
   end

   // ========================================
   // Read decode
   // ========================================

   always_comb begin
      case (apb_paddr_i)
         cache_pkg::REG_HIT:        rdata = read_hit_q + write_hit_q;
         cache_pkg::REG_MISS:       rdata = read_miss_q + write_miss_q;
         cache_pkg::REG_READ_HIT:   rdata = read_hit_q;
         cache_pkg::REG_READ_MISS:  rdata = read_miss_q;
         cache_pkg::REG_WRITE_HIT:  rdata = write_hit_q;
         cache_pkg::REG_WRITE_MISS: rdata = write_miss_q;
         cache_pkg::REG_WTB_EMPTY:  rdata = cache_pkg::data_t'(wtb_empty_i);
         cache_pkg::REG_WTB_FULL:   rdata = cache_pkg::data_t'(wtb_full_i);
         cache_pkg::REG_VERSION:    rdata = cache_pkg::CACHE_VERSION;
         // Command offsets and holes read zero.
         default:                   rdata = '0;
      endcase
   end

   assign apb_prdata_o = (apb_psel_i && !apb_pwrite_i) ? rdata : '0;

endmodule

//--- cache_top.sv
// Top level of the write-through data cache.
// Front, core, back end and APB control block.

`timescale 1ns/1ps

module cache_top #(
   parameter int ADDR_W         = cache_pkg::ADDR_W,
   parameter int DATA_W         = cache_pkg::DATA_W,
   parameter int IDX_W          = 4,
   parameter int WTB_DEPTH_LOG2 = 2
) (
   input  logic                 clk_i,
   input  logic                 arst_i,
   // CPU port.
   input  logic                 cpu_valid_i,
   input  logic                 cpu_we_i,
   input  logic [ADDR_W-1:0]    cpu_addr_i,
   input  logic [DATA_W-1:0]    cpu_wdata_i,
   output logic                 cpu_ready_o,
   output logic [DATA_W-1:0]    cpu_rdata_o,
   // Memory port.
   output logic                 mem_valid_o,
   output logic                 mem_we_o,
   output logic [ADDR_W-1:0]    mem_addr_o,
   output logic [DATA_W-1:0]    mem_wdata_o,
   input  logic                 mem_ready_i,
   input  logic [DATA_W-1:0]    mem_rdata_i,
   // APB port.
   input  logic                 apb_psel_i,
   input  logic                 apb_penable_i,
   input  logic                 apb_pwrite_i,
   input  cache_pkg::apb_addr_t apb_paddr_i,
   input  logic [DATA_W-1:0]    apb_pwdata_i,
   output logic [DATA_W-1:0]    apb_prdata_o,
   output logic                 apb_pready_o
);

   // Front to core.
   logic             req_valid;
   logic             req_we;
   cache_pkg::addr_t req_addr;
   cache_pkg::data_t req_wdata;
   logic             req_done;
   cache_pkg::data_t rsp_data;

   // Core to back end.
   logic             wtb_push;
   cache_pkg::addr_t wtb_addr;
   cache_pkg::data_t wtb_data;
   logic             wtb_full;
   logic             wtb_empty;
   logic             rd_req;
   cache_pkg::addr_t rd_addr;
   logic             rd_done;
   cache_pkg::data_t rd_data;

   // Events and control.
   logic             read_hit;
   logic             read_miss;
   logic             write_hit;
   logic             write_miss;
   logic             invalidate;

   cache_front u_front (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .cpu_valid_i (cpu_valid_i),
      .cpu_we_i    (cpu_we_i),
      .cpu_addr_i  (cpu_addr_i),
      .cpu_wdata_i (cpu_wdata_i),
      .cpu_ready_o (cpu_ready_o),
      .cpu_rdata_o (cpu_rdata_o),
      .req_done_i  (req_done),
      .rsp_data_i  (rsp_data),
      .req_valid_o (req_valid),
      .req_we_o    (req_we),
      .req_addr_o  (req_addr),
      .req_wdata_o (req_wdata)
   );

   cache_core #(
      .IDX_W (IDX_W)
   ) u_core (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .req_valid_i  (req_valid),
      .req_we_i     (req_we),
      .req_addr_i   (req_addr),
      .req_wdata_i  (req_wdata),
      .req_done_o   (req_done),
      .rsp_data_o   (rsp_data),
      .invalidate_i (invalidate),
      .wtb_full_i   (wtb_full),
      .wtb_empty_i  (wtb_empty),
      .wtb_push_o   (wtb_push),
      .wtb_addr_o   (wtb_addr),
      .wtb_data_o   (wtb_data),
      .rd_done_i    (rd_done),
      .rd_data_i    (rd_data),
      .rd_req_o     (rd_req),
      .rd_addr_o    (rd_addr),
      .read_hit_o   (read_hit),
      .read_miss_o  (read_miss),
      .write_hit_o  (write_hit),
      .write_miss_o (write_miss)
   );

   cache_back_end #(
      .WTB_DEPTH_LOG2 (WTB_DEPTH_LOG2)
   ) u_back_end (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .wtb_push_i  (wtb_push),
      .wtb_addr_i  (wtb_addr),
      .wtb_data_i  (wtb_data),
      .wtb_full_o  (wtb_full),
      .wtb_empty_o (wtb_empty),
      .rd_req_i    (rd_req),
      .rd_addr_i   (rd_addr),
      .rd_done_o   (rd_done),
      .rd_data_o   (rd_data),
      .mem_ready_i (mem_ready_i),
      .mem_rdata_i (mem_rdata_i),
      .mem_valid_o (mem_valid_o),
      .mem_we_o    (mem_we_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o)
   );

   cache_ctrl u_ctrl (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .apb_psel_i    (apb_psel_i),
      .apb_penable_i (apb_penable_i),
      .apb_pwrite_i  (apb_pwrite_i),
      .apb_paddr_i   (apb_paddr_i),
      .apb_pwdata_i  (apb_pwdata_i),
      .apb_prdata_o  (apb_prdata_o),
      .apb_pready_o  (apb_pready_o),
      .read_hit_i    (read_hit),
      .read_miss_i   (read_miss),
      .write_hit_i   (write_hit),
      .write_miss_i  (write_miss),
      .wtb_empty_i   (wtb_empty),
      .wtb_full_i    (wtb_full),
      .invalidate_o  (invalidate)
   );

endmodule

//--- tb_cache.sv
// Testbench for the write-through data cache.
// CPU and APB drivers, backing memory model, reference model and checks.

`timescale 1ns/1ps

module tb_cache;

   localparam int IDX_W          = 4;
   localparam int WTB_DEPTH_LOG2 = 2;
   localparam int LINES          = 1 << IDX_W;
   // Upper bound of CPU and APB transfers over all tests.
   localparam int N_TXN           = 600;
   localparam int WATCHDOG_CYCLES = 200 * N_TXN + 1000;

   logic                 clk_i;
   logic                 arst_i;
   logic                 cpu_valid_i;
   logic                 cpu_we_i;
   cache_pkg::addr_t     cpu_addr_i;
   cache_pkg::data_t     cpu_wdata_i;
   logic                 cpu_ready_o;
   cache_pkg::data_t     cpu_rdata_o;
   logic                 mem_valid_o;
   logic                 mem_we_o;
   cache_pkg::addr_t     mem_addr_o;
   cache_pkg::data_t     mem_wdata_o;
   logic                 mem_ready_i;
   cache_pkg::data_t     mem_rdata_i;
   logic                 apb_psel_i;
   logic                 apb_penable_i;
   logic                 apb_pwrite_i;
   cache_pkg::apb_addr_t apb_paddr_i;
   cache_pkg::data_t     apb_pwdata_i;
   cache_pkg::data_t     apb_prdata_o;
   logic                 apb_pready_o;

   int               seed = 32'h0887225a;
   int               errors;
   int               checks;
   string            test_name;
   cache_pkg::data_t exp_rdata;
   bit               slow_mem;
   bit               burst_done;

   // Backing memory and the shadow copy of what it should hold.
   cache_pkg::data_t mem_model  [0:65535];
   cache_pkg::data_t shadow_mem [0:65535];

   // Reference tag table and expected counters.
   logic [LINES-1:0] ref_valid;
   cache_pkg::addr_t ref_tag [LINES];
   cache_pkg::cnt_t  exp_rh;
   cache_pkg::cnt_t  exp_rm;
   cache_pkg::cnt_t  exp_wh;
   cache_pkg::cnt_t  exp_wm;

   cache_top #(
      .IDX_W          (IDX_W),
      .WTB_DEPTH_LOG2 (WTB_DEPTH_LOG2)
   ) u_dut (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .cpu_valid_i   (cpu_valid_i),
      .cpu_we_i      (cpu_we_i),
      .cpu_addr_i    (cpu_addr_i),
      .cpu_wdata_i   (cpu_wdata_i),
      .cpu_ready_o   (cpu_ready_o),
      .cpu_rdata_o   (cpu_rdata_o),
      .mem_valid_o   (mem_valid_o),
      .mem_we_o      (mem_we_o),
      .mem_addr_o    (mem_addr_o),
      .mem_wdata_o   (mem_wdata_o),
      .mem_ready_i   (mem_ready_i),
      .mem_rdata_i   (mem_rdata_i),
      .apb_psel_i    (apb_psel_i),
      .apb_penable_i (apb_penable_i),
      .apb_pwrite_i  (apb_pwrite_i),
      .apb_paddr_i   (apb_paddr_i),
      .apb_pwdata_i  (apb_pwdata_i),
      .apb_prdata_o  (apb_prdata_o),
      .apb_pready_o  (apb_pready_o)
   );

   // 8 ns clock.
   always #4 clk_i = ~clk_i;

   // Read data must match the shadow memory in the ready cycle.
   assert property (@(posedge clk_i) disable iff (arst_i)
      (cpu_ready_o && !cpu_we_i) |-> (cpu_rdata_o == exp_rdata))
   else begin
      $display("FAIL %s: read data expected %h actual %h",
               test_name, exp_rdata, $sampled(cpu_rdata_o));
      errors++;
   end

   // APB has no wait states.
   assert property (@(posedge clk_i) disable iff (arst_i)
      (apb_psel_i && apb_penable_i) |-> apb_pready_o)
   else begin
      $display("FAIL %s: apb_pready_o expected 1 actual %b",
               test_name, $sampled(apb_pready_o));
      errors++;
   end

   // ========================================
   // Memory model
   // ========================================

   function automatic cache_pkg::data_t init_word(input cache_pkg::addr_t a);
      return {a ^ 16'hc35a, a};
   endfunction

   // 32 test addresses, two tags per line.
   function automatic cache_pkg::addr_t addr_of(input logic [4:0] sel);
      return {7'h00, sel[4], 4'h0, sel[3:0]};
   endfunction

   // Ready after 0 to 3 wait cycles, or 3 when the memory is slow.
   always @(posedge clk_i) begin
      bit accepted;
      bit pending;
      int wait_cnt;
      accepted = mem_valid_o && mem_ready_i;
      if (accepted && mem_we_o)
         mem_model[mem_addr_o] = mem_wdata_o;
      #1;
      if (accepted)
         pending = 0;
      mem_ready_i = 1'b0;
      if (mem_valid_o) begin
         if (!pending) begin
            pending  = 1;
            wait_cnt = slow_mem ? 3 : ($random(seed) & 3);
         end
         if (wait_cnt == 0) begin
            mem_ready_i = 1'b1;
            mem_rdata_i = mem_model[mem_addr_o];
         end else begin
            wait_cnt--;
         end
      end
   end

   // ========================================
   // Drivers and reference model
   // ========================================

   task automatic cpu_access(input logic we, input cache_pkg::addr_t a,
                             input cache_pkg::data_t d);
      logic [IDX_W-1:0] idx;
      logic             hit;
      idx = a[IDX_W-1:0];
      hit = ref_valid[idx] && (ref_tag[idx] == a);
      if (we) begin
         if (hit)
            exp_wh++;
         else
            exp_wm++;
         shadow_mem[a] = d;
      end else begin
         if (hit) begin
            exp_rh++;
         end else begin
            exp_rm++;
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = a;
         end
         exp_rdata = shadow_mem[a];
         checks++;
      end
      cpu_we_i    = we;
      cpu_addr_i  = a;
      cpu_wdata_i = d;
      cpu_valid_i = 1'b1;
      do @(posedge clk_i); while (!cpu_ready_o);
      #1;
      cpu_valid_i = 1'b0;
   endtask

   task automatic random_access();
      int r;
      r = $random(seed);
      cpu_access(r[6], addr_of(r[4:0]), $random(seed));
   endtask

   task automatic apb_write(input cache_pkg::apb_addr_t a, input cache_pkg::data_t d);
      apb_psel_i   = 1'b1;
      apb_pwrite_i = 1'b1;
      apb_paddr_i  = a;
      apb_pwdata_i = d;
      @(posedge clk_i);
      #1 apb_penable_i = 1'b1;
      do @(posedge clk_i); while (!apb_pready_o);
      #1;
      apb_psel_i    = 1'b0;
      apb_penable_i = 1'b0;
      apb_pwrite_i  = 1'b0;
   endtask

   task automatic apb_read(input cache_pkg::apb_addr_t a, output cache_pkg::data_t d);
      apb_psel_i   = 1'b1;
      apb_pwrite_i = 1'b0;
      apb_paddr_i  = a;
      @(posedge clk_i);
      #1 apb_penable_i = 1'b1;
      do @(posedge clk_i); while (!apb_pready_o);
      d = apb_prdata_o;
      #1;
      apb_psel_i    = 1'b0;
      apb_penable_i = 1'b0;
   endtask

   task automatic apb_check(input cache_pkg::apb_addr_t a, input cache_pkg::data_t exp);
      cache_pkg::data_t got;
      apb_read(a, got);
      checks++;
      assert (got == exp) else begin
         $display("FAIL %s: reg 0x%h expected %h actual %h", test_name, a, exp, got);
         errors++;
      end
   endtask

   task automatic check_counters();
      apb_check(cache_pkg::REG_HIT, exp_rh + exp_wh);
      apb_check(cache_pkg::REG_MISS, exp_rm + exp_wm);
      apb_check(cache_pkg::REG_READ_HIT, exp_rh);
      apb_check(cache_pkg::REG_READ_MISS, exp_rm);
      apb_check(cache_pkg::REG_WRITE_HIT, exp_wh);
      apb_check(cache_pkg::REG_WRITE_MISS, exp_wm);
   endtask

   task automatic clear_counters();
      apb_write(cache_pkg::REG_RST_CNTRS, 32'h0);
      exp_rh = '0;
      exp_rm = '0;
      exp_wh = '0;
      exp_wm = '0;
   endtask

   // ========================================
   // Test sequence
   // ========================================

   initial begin
      int               a;
      int               quiet;
      bit               saw_full;
      logic [LINES-1:0] cached;
      cache_pkg::data_t v;
      clk_i = 0;
      arst_i = 1;
      cpu_valid_i = 0;
      cpu_we_i = 0;
      cpu_addr_i = '0;
      cpu_wdata_i = '0;
      mem_ready_i = 0;
      mem_rdata_i = '0;
      apb_psel_i = 0;
      apb_penable_i = 0;
      apb_pwrite_i = 0;
      apb_paddr_i = '0;
      apb_pwdata_i = '0;
      errors = 0;
      checks = 0;
      slow_mem = 0;
      ref_valid = '0;
      exp_rh = '0;
      exp_rm = '0;
      exp_wh = '0;
      exp_wm = '0;
      for (a = 0; a < 65536; a++) begin
         mem_model[a]  = init_word(cache_pkg::addr_t'(a));
         shadow_mem[a] = init_word(cache_pkg::addr_t'(a));
      end
      repeat (16) @(posedge clk_i);
      #1 arst_i = 0;

      test_name = "version";
      apb_check(cache_pkg::REG_VERSION, cache_pkg::CACHE_VERSION);
      apb_check(8'h3C, 32'h0);
      check_counters();

      // Write miss left in the buffer, then a read of the same word.
      test_name = "read data";
      cpu_access(1'b1, addr_of(5'd5), 32'hdead_beef);
      cpu_access(1'b0, addr_of(5'd5), '0);
      cpu_access(1'b0, addr_of(5'd5), '0);
      cpu_access(1'b1, addr_of(5'd5), 32'h1234_5678);
      cpu_access(1'b0, addr_of(5'd5), '0);
      cpu_access(1'b0, addr_of(5'd21), '0);
      cpu_access(1'b0, addr_of(5'd5), '0);

      test_name = "random";
      repeat (300) random_access();
      check_counters();

      test_name = "counter clear";
      clear_counters();
      check_counters();
      repeat (6) random_access();
      check_counters();

      // Every line is valid after this; all later reads must miss.
      test_name = "invalidate";
      for (a = 0; a < 32; a++)
         cpu_access(1'b0, addr_of(a[4:0]), '0);
      clear_counters();
      apb_write(cache_pkg::REG_INVALIDATE, 32'h0);
      cached    = ref_valid;
      ref_valid = '0;
      for (a = 0; a < LINES; a++) begin
         if (cached[a])
            cpu_access(1'b0, ref_tag[a], '0);
      end
      check_counters();

      test_name = "write buffer";
      slow_mem   = 1;
      burst_done = 0;
      saw_full   = 0;
      fork
         begin
            for (a = 0; a < 12; a++)
               cpu_access(1'b1, addr_of(a[4:0]), $random(seed));
            burst_done = 1;
         end
         begin
            while (!burst_done) begin
               apb_read(cache_pkg::REG_WTB_FULL, v);
               if (v == 32'h1)
                  saw_full = 1;
            end
         end
      join
      checks++;
      assert (saw_full) else begin
         $display("Write buffer never reported full during the slow burst");
         errors++;
      end
      slow_mem = 0;
      quiet    = 0;
      while (quiet < 8) begin
         @(posedge clk_i);
         quiet = mem_valid_o ? 0 : quiet + 1;
      end
      #1;
      apb_check(cache_pkg::REG_WTB_EMPTY, 32'h1);
      for (a = 0; a < 32; a++) begin
         checks++;
         assert (mem_model[addr_of(a[4:0])] == shadow_mem[addr_of(a[4:0])]) else begin
            $display("FAIL %s: mem[%h] expected %h actual %h", test_name,
                     addr_of(a[4:0]), shadow_mem[addr_of(a[4:0])],
                     mem_model[addr_of(a[4:0])]);
            errors++;
         end
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // Watchdog.
   initial begin
      #(WATCHDOG_CYCLES * 8);
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Errors found");
      $finish;
   end

endmodule

//--- list.f
cache_pkg.sv
cache_front.sv
cache_core.sv
cache_back_end.sv
cache_ctrl.sv
cache_top.sv
tb_cache.sv

//--- run.sh
#!/bin/sh
# Compile and run the cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f list.f -o sim_cache
out=$(./obj_dir/sim_cache)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
   exit 0
fi
exit 1
